// ==== compile.f ====
+incdir+src
src/axi_regs_pkg.sv
src/reg_req_if.sv
src/reg_rsp_if.sv
src/axi_lite_decode.sv
src/reg_execute.sv
src/axi_lite_result.sv
src/axi_regs_top.sv
verif/tb_axi_regs.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the AXI4-Lite register block testbench with Verilator.
# Exits non-zero unless the simulation prints the pass message.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert \
    --top-module tb_axi_regs \
    -Mdir obj_dir -o Vtb_axi_regs \
    -f compile.f; then
  echo "Verilator build failed"
  exit 1
fi

sim_output="$(./obj_dir/Vtb_axi_regs)"
sim_status=$?
printf '%s\n' "$sim_output"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_output" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1

// ==== src/axi_lite_decode.sv ====
/*
  AXI4-Lite AW/W/AR acceptance, one transaction in flight at a time.
  Writes win over a read offered in the same cycle. No WSTRB, no PROT.
  Address bits 1:0 are ignored; word index >= REG_COUNT is flagged invalid.
*/
`timescale 1ns/1ps
`include "axi_regs_params.svh"

module axi_lite_decode (
  input  logic                         clk,
  input  logic                         w_axi_rst,

  input  logic                         i_awvalid,
  input  logic [`AXI_ADDR_WIDTH-1:0]   i_awaddr,
  output logic                         o_awready,

  input  logic                         i_wvalid,
  input  logic [`AXI_DATA_WIDTH-1:0]   i_wdata,
  output logic                         o_wready,

  input  logic                         i_arvalid,
  input  logic [`AXI_ADDR_WIDTH-1:0]   i_araddr,
  output logic                         o_arready,

  input  logic                         i_busy,
  reg_req_if.source                    req
);
  import axi_regs_pkg::*;

  localparam int WORD_W = `AXI_ADDR_WIDTH - 2;

  decode_state_e               state_q;
  decode_state_e               state_d;
  logic                        aw_got_q;
  logic                        w_got_q;
  logic                        busy_seen_q;
  logic [`AXI_ADDR_WIDTH-1:0]  addr_q;
  logic [`AXI_DATA_WIDTH-1:0]  wdata_q;
  logic                        idle;
  logic                        aw_hs;
  logic                        w_hs;
  logic                        ar_hs;
  logic [WORD_W-1:0]           word_idx;

  assign idle = (state_q == DEC_IDLE);

  // AW and W taken independently, each once per write
  assign o_awready = idle && !aw_got_q;
  assign o_wready  = idle && !w_got_q;
  // Read held off by any pending or offered write half
  assign o_arready = idle && !aw_got_q && !w_got_q && !i_awvalid && !i_wvalid;

  assign aw_hs = i_awvalid && o_awready;
  assign w_hs  = i_wvalid && o_wready;
  assign ar_hs = i_arvalid && o_arready;

  always_comb begin
    state_d = state_q;
    case (state_q)
      DEC_IDLE: begin
        // Both write halves present, counting this cycle's handshakes
        if ((aw_got_q || aw_hs) && (w_got_q || w_hs)) begin
          state_d = DEC_WRITE_REQ;
        end else if (ar_hs) begin
          state_d = DEC_READ_REQ;
        end
      end
      DEC_WRITE_REQ,
      DEC_READ_REQ: begin
        state_d = DEC_WAIT;
      end
      DEC_WAIT: begin
        // Response went out and the master has taken it
        if (busy_seen_q && !i_busy) begin
          state_d = DEC_IDLE;
        end
      end
      default: begin
        state_d = DEC_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (w_axi_rst) begin
      state_q     <= DEC_IDLE;
      aw_got_q    <= 1'b0;
      w_got_q     <= 1'b0;
      busy_seen_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // Capture flags clear as the write request is issued
      if (state_d == DEC_WRITE_REQ) begin
        aw_got_q <= 1'b0;
        w_got_q  <= 1'b0;
      end else begin
        if (aw_hs) begin
          aw_got_q <= 1'b1;
        end
        if (w_hs) begin
          w_got_q <= 1'b1;
        end
      end
      // Remember that busy rose while waiting
      busy_seen_q <= (state_d == DEC_WAIT) && (busy_seen_q || i_busy);
    end
  end

  // Shared address holder, AW and AR never accepted together
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      addr_q <= i_awaddr;
    end else if (ar_hs) begin
      addr_q <= i_araddr;
    end
    if (w_hs) begin
      wdata_q <= i_wdata;
    end
  end

  // Drop byte offset
  assign word_idx = addr_q[`AXI_ADDR_WIDTH-1:2];

  // Request pulse lasts the single cycle spent in a REQ state
  assign req.valid   = (state_q == DEC_WRITE_REQ) || (state_q == DEC_READ_REQ);
  assign req.write   = (state_q == DEC_WRITE_REQ);
  assign req.index   = reg_index_e'(word_idx[1:0]);
  assign req.wdata   = wdata_q;
  assign req.invalid = (word_idx >= WORD_W'(`REG_COUNT));

endmodule

// ==== src/axi_lite_result.sv ====
/*
  B and R channel holding registers.
  Valid and payload stay steady until the matching ready; busy covers both.
*/
`timescale 1ns/1ps
`include "axi_regs_params.svh"

module axi_lite_result (
  input  logic                         clk,
  input  logic                         w_axi_rst,
  input  logic                         i_bready,
  input  logic                         i_rready,
  reg_rsp_if.sink                      rsp,

  output logic                         o_bvalid,
  output logic [1:0]                   o_bresp,
  output logic                         o_rvalid,
  output logic [`AXI_DATA_WIDTH-1:0]   o_rdata,
  output logic [1:0]                   o_rresp,
  output logic                         o_busy
);
  import axi_regs_pkg::*;

  logic                        bvalid_q;
  logic                        rvalid_q;
  axi_resp_e                   bresp_q;
  axi_resp_e                   rresp_q;
  logic [`AXI_DATA_WIDTH-1:0]  rdata_q;

  always_ff @(posedge clk) begin
    if (w_axi_rst) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      // Write outcome goes to B
      if (rsp.valid && rsp.write) begin
        bvalid_q <= 1'b1;
      end else if (bvalid_q && i_bready) begin
        bvalid_q <= 1'b0;
      end
      // Read outcome goes to R
      if (rsp.valid && !rsp.write) begin
        rvalid_q <= 1'b1;
      end else if (rvalid_q && i_rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Payload loads only with the pulse, so it holds under back-pressure
  always_ff @(posedge clk) begin
    if (rsp.valid) begin
      if (rsp.write) begin
        bresp_q <= rsp.resp;
      end else begin
        rresp_q <= rsp.resp;
        rdata_q <= rsp.rdata;
      end
    end
  end

  assign o_bvalid = bvalid_q;
  assign o_bresp  = bresp_q;
  assign o_rvalid = rvalid_q;
  assign o_rresp  = rresp_q;
  assign o_rdata  = rdata_q;

  // Decode stays parked while either channel holds a response
  assign o_busy = bvalid_q || rvalid_q;

endmodule

// ==== src/axi_regs_params.svh ====
/*
  Bus widths, register count and VERSION field layout for the register block.
  Status packing assumes a 32-bit data bus with two 16-bit counters.
*/
`ifndef AXI_REGS_PARAMS_SVH
`define AXI_REGS_PARAMS_SVH

// AXI4-Lite bus widths
`define AXI_ADDR_WIDTH      8
`define AXI_DATA_WIDTH      32

// Number of 32-bit register words decoded
`define REG_COUNT           4

// Version values
`define VER_MAJOR           1
`define VER_MINOR           0
`define VER_REVISION        0

// Bit positions inside the VERSION word, all other bits read zero
`define VER_MAJOR_RANGE     31:28
`define VER_MINOR_RANGE     27:20
`define VER_REVISION_RANGE  19:16

`endif

// ==== src/axi_regs_pkg.sv ====
/*
  Shared types for the register block.
  Register index encoding is the word address, i.e. byte address bits 3:2.
*/
package axi_regs_pkg;

  // Register word index
  typedef enum logic [1:0] {
    REG_CONTROL = 2'd0,
    REG_STATUS  = 2'd1,
    REG_VERSION = 2'd2,
    REG_SCRATCH = 2'd3
  } reg_index_e;

  // AXI response codes, only the two used here
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

  // Decode FSM
  typedef enum logic [1:0] {
    DEC_IDLE,
    DEC_WRITE_REQ,
    DEC_READ_REQ,
    DEC_WAIT
  } decode_state_e;

endpackage

// ==== src/axi_regs_top.sv ====
/*
  AXI4-Lite register block top: decode, execute, result.
  Synchronous active-high reset. Write strobes and PROT are not provided.
  Latency from last address/data handshake to BVALID or RVALID is 3 cycles.
*/
`timescale 1ns/1ps
`include "axi_regs_params.svh"

module axi_regs_top (
  input  logic                         clk,
  input  logic                         w_axi_rst,

  // Write address
  input  logic                         i_awvalid,
  input  logic [`AXI_ADDR_WIDTH-1:0]   i_awaddr,
  output logic                         o_awready,

  // Write data
  input  logic                         i_wvalid,
  input  logic [`AXI_DATA_WIDTH-1:0]   i_wdata,
  output logic                         o_wready,

  // Write response
  output logic                         o_bvalid,
  input  logic                         i_bready,
  output logic [1:0]                   o_bresp,

  // Read address
  input  logic                         i_arvalid,
  input  logic [`AXI_ADDR_WIDTH-1:0]   i_araddr,
  output logic                         o_arready,

  // Read data
  output logic                         o_rvalid,
  input  logic                         i_rready,
  output logic [`AXI_DATA_WIDTH-1:0]   o_rdata,
  output logic [1:0]                   o_rresp,

  // CONTROL register contents
  output logic [`AXI_DATA_WIDTH-1:0]   o_control
);

  reg_req_if req_if ();
  reg_rsp_if rsp_if ();

  // Response pending, from result back to decode
  logic busy;

  axi_lite_decode axi_lite_decode_inst (
    .clk        (clk),
    .w_axi_rst  (w_axi_rst),
    .i_awvalid  (i_awvalid),
    .i_awaddr   (i_awaddr),
    .o_awready  (o_awready),
    .i_wvalid   (i_wvalid),
    .i_wdata    (i_wdata),
    .o_wready   (o_wready),
    .i_arvalid  (i_arvalid),
    .i_araddr   (i_araddr),
    .o_arready  (o_arready),
    .i_busy     (busy),
    .req        (req_if.source)
  );

  reg_execute reg_execute_inst (
    .clk        (clk),
    .w_axi_rst  (w_axi_rst),
    .req        (req_if.sink),
    .rsp        (rsp_if.source),
    .o_control  (o_control)
  );

  axi_lite_result axi_lite_result_inst (
    .clk        (clk),
    .w_axi_rst  (w_axi_rst),
    .i_bready   (i_bready),
    .i_rready   (i_rready),
    .rsp        (rsp_if.sink),
    .o_bvalid   (o_bvalid),
    .o_bresp    (o_bresp),
    .o_rvalid   (o_rvalid),
    .o_rdata    (o_rdata),
    .o_rresp    (o_rresp),
    .o_busy     (busy)
  );

endmodule

// ==== src/reg_execute.sv ====
/*
  Register file: CONTROL and SCRATCH read/write, STATUS and VERSION read-only.
  STATUS packs read count in 31:16 and write count in 15:0, both wrapping.
  Counters include failed accesses; a STATUS read returns pre-read counts.
*/
`timescale 1ns/1ps
`include "axi_regs_params.svh"

module reg_execute (
  input  logic                         clk,
  input  logic                         w_axi_rst,
  reg_req_if.sink                      req,
  reg_rsp_if.source                    rsp,
  output logic [`AXI_DATA_WIDTH-1:0]   o_control
);
  import axi_regs_pkg::*;

  // Field types sized by the VERSION ranges
  typedef logic [`VER_MAJOR_RANGE]    ver_major_t;
  typedef logic [`VER_MINOR_RANGE]    ver_minor_t;
  typedef logic [`VER_REVISION_RANGE] ver_revision_t;

  logic [`AXI_DATA_WIDTH-1:0]  control_q;
  logic [`AXI_DATA_WIDTH-1:0]  scratch_q;
  logic [15:0]                 wr_count_q;
  logic [15:0]                 rd_count_q;
  logic [`AXI_DATA_WIDTH-1:0]  version_word;
  logic [`AXI_DATA_WIDTH-1:0]  read_mux;
  logic                        rsp_valid_q;
  logic                        rsp_write_q;
  logic [`AXI_DATA_WIDTH-1:0]  rdata_q;
  axi_resp_e                   resp_q;

  // Constant VERSION word, unused bits zero
  always_comb begin
    version_word                       = '0;
    version_word[`VER_MAJOR_RANGE]     = ver_major_t'(`VER_MAJOR);
    version_word[`VER_MINOR_RANGE]     = ver_minor_t'(`VER_MINOR);
    version_word[`VER_REVISION_RANGE]  = ver_revision_t'(`VER_REVISION);
  end

  // Read select
  always_comb begin
    case (req.index)
      REG_CONTROL: read_mux = control_q;
      REG_STATUS:  read_mux = `AXI_DATA_WIDTH'({rd_count_q, wr_count_q});
      REG_VERSION: read_mux = version_word;
      REG_SCRATCH: read_mux = scratch_q;
      default:     read_mux = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (w_axi_rst) begin
      control_q   <= '0;
      scratch_q   <= '0;
      wr_count_q  <= '0;
      rd_count_q  <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      // Response pulse one cycle behind the request
      rsp_valid_q <= req.valid;
      if (req.valid) begin
        // Count every access, good or bad
        if (req.write) begin
          wr_count_q <= wr_count_q + 16'd1;
        end else begin
          rd_count_q <= rd_count_q + 16'd1;
        end
        // Only the writable words take data
        if (req.write && !req.invalid) begin
          case (req.index)
            REG_CONTROL: control_q <= req.wdata;
            REG_SCRATCH: scratch_q <= req.wdata;
            default: begin
            end
          endcase
        end
      end
    end
  end

  // Outcome payload, meaningful only with the pulse
  always_ff @(posedge clk) begin
    if (req.valid) begin
      rsp_write_q <= req.write;
      resp_q      <= req.invalid ? RESP_SLVERR : RESP_OKAY;
      // Zero for writes and out-of-range reads
      rdata_q     <= (req.write || req.invalid) ? '0 : read_mux;
    end
  end

  assign rsp.valid = rsp_valid_q;
  assign rsp.write = rsp_write_q;
  assign rsp.rdata = rdata_q;
  assign rsp.resp  = resp_q;

  assign o_control = control_q;

endmodule

// ==== src/reg_req_if.sv ====
/*
  Register request from decode to execute.
  Valid is a single-cycle pulse with no ready; the sink must act on every pulse.
*/
`timescale 1ns/1ps
`include "axi_regs_params.svh"

interface reg_req_if;
  import axi_regs_pkg::*;

  // One pulse per accepted transaction
  logic                        valid;
  // High for write, low for read
  logic                        write;
  reg_index_e                  index;
  logic [`AXI_DATA_WIDTH-1:0]  wdata;
  // Address beyond the register map
  logic                        invalid;

  modport source (output valid, output write, output index, output wdata, output invalid);
  modport sink   (input valid, input write, input index, input wdata, input invalid);

endinterface

// ==== src/reg_rsp_if.sv ====
/*
  Register outcome from execute to result.
  Valid is a single-cycle pulse; rdata is zero for writes and failed reads.
*/
`timescale 1ns/1ps
`include "axi_regs_params.svh"

interface reg_rsp_if;
  import axi_regs_pkg::*;

  // One pulse per completed register access
  logic                        valid;
  // Selects B or R channel downstream
  logic                        write;
  logic [`AXI_DATA_WIDTH-1:0]  rdata;
  axi_resp_e                   resp;

  modport source (output valid, output write, output rdata, output resp);
  modport sink   (input valid, input write, input rdata, input resp);

endinterface

// ==== verif/tb_axi_regs.sv ====
/*
  Testbench for the AXI4-Lite register block, one transaction at a time.
  Concurrent assertions compare against a reference register model.
  Needs a simulator with assertion and timing support (Verilator --assert --timing).
*/
`timescale 1ns/1ps
`include "axi_regs_params.svh"

module tb_axi_regs;
  import axi_regs_pkg::*;

  localparam int RESET_CYCLES   = 8;
  // 64 transactions, each well under 30 cycles even with a full stall
  localparam int TXN_COUNT      = 64;
  localparam int CYCLES_PER_TXN = 30;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + TXN_COUNT * CYCLES_PER_TXN;
  // Major 1 in 31:28, minor 0 in 27:20, revision 0 in 19:16
  localparam logic [31:0] VERSION_WORD = {4'd1, 8'd0, 4'd0, 16'd0};

  logic                        clk;
  logic                        w_axi_rst;
  logic                        i_awvalid;
  logic [`AXI_ADDR_WIDTH-1:0]  i_awaddr;
  logic                        o_awready;
  logic                        i_wvalid;
  logic [`AXI_DATA_WIDTH-1:0]  i_wdata;
  logic                        o_wready;
  logic                        o_bvalid;
  logic                        i_bready;
  logic [1:0]                  o_bresp;
  logic                        i_arvalid;
  logic [`AXI_ADDR_WIDTH-1:0]  i_araddr;
  logic                        o_arready;
  logic                        o_rvalid;
  logic                        i_rready;
  logic [`AXI_DATA_WIDTH-1:0]  o_rdata;
  logic [1:0]                  o_rresp;
  logic [`AXI_DATA_WIDTH-1:0]  o_control;

  // Reference model
  logic [`AXI_DATA_WIDTH-1:0]  m_control;
  logic [`AXI_DATA_WIDTH-1:0]  m_scratch;
  logic [15:0]                 m_wr_count;
  logic [15:0]                 m_rd_count;
  axi_resp_e                   exp_bresp;
  axi_resp_e                   exp_rresp;
  logic [`AXI_DATA_WIDTH-1:0]  exp_rdata;

  // Handshake tracking for latency checks
  logic                        aw_seen;
  logic                        w_seen;
  int                          wr_lat;
  int                          rd_lat;
  int                          reads_accepted;

  int                          error_count;
  int                          txn_count;
  int                          cycle_count;
  int                          ar_before;
  logic [31:0]                 rng_state;
  logic [`AXI_ADDR_WIDTH-1:0]  rand_addr;

  axi_regs_top axi_regs_top_inst (
    .clk       (clk),
    .w_axi_rst (w_axi_rst),
    .i_awvalid (i_awvalid),
    .i_awaddr  (i_awaddr),
    .o_awready (o_awready),
    .i_wvalid  (i_wvalid),
    .i_wdata   (i_wdata),
    .o_wready  (o_wready),
    .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .o_bresp   (o_bresp),
    .i_arvalid (i_arvalid),
    .i_araddr  (i_araddr),
    .o_arready (o_arready),
    .o_rvalid  (o_rvalid),
    .i_rready  (i_rready),
    .o_rdata   (o_rdata),
    .o_rresp   (o_rresp),
    .o_control (o_control)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int word_index(input logic [`AXI_ADDR_WIDTH-1:0] addr);
    return int'(addr >> 2);
  endfunction

  // Order 0 offers AW and W together, 1 leads with AW, 2 leads with W
  task automatic send_write_halves(input logic [`AXI_ADDR_WIDTH-1:0] addr,
                                   input logic [`AXI_DATA_WIDTH-1:0] data,
                                   input int order);
    bit aw_done;
    bit w_done;
    bit aw_hs;
    bit w_hs;
    aw_done   = 1'b0;
    w_done    = 1'b0;
    i_awaddr  = addr;
    i_wdata   = data;
    i_awvalid = (order != 2);
    i_wvalid  = (order != 1);
    while (!(aw_done && w_done)) begin
      aw_hs = i_awvalid && o_awready;
      w_hs  = i_wvalid && o_wready;
      @(negedge clk);
      if (aw_hs) begin
        aw_done   = 1'b1;
        i_awvalid = 1'b0;
      end
      if (w_hs) begin
        w_done   = 1'b1;
        i_wvalid = 1'b0;
      end
      // Second half follows once the first is taken
      if (aw_done && !w_done) begin
        i_wvalid = 1'b1;
      end
      if (w_done && !aw_done) begin
        i_awvalid = 1'b1;
      end
    end
    // Only CONTROL and SCRATCH take data, bad words change nothing
    exp_bresp = RESP_OKAY;
    case (word_index(addr))
      0: m_control = data;
      1, 2: begin
      end
      3: m_scratch = data;
      default: exp_bresp = RESP_SLVERR;
    endcase
    m_wr_count = m_wr_count + 16'd1;
    txn_count++;
  endtask

  task automatic send_read_addr(input logic [`AXI_ADDR_WIDTH-1:0] addr);
    bit ar_hs;
    ar_hs     = 1'b0;
    i_araddr  = addr;
    i_arvalid = 1'b1;
    while (!ar_hs) begin
      ar_hs = i_arvalid && o_arready;
      @(negedge clk);
    end
    i_arvalid = 1'b0;
    exp_rresp = RESP_OKAY;
    // STATUS shows counts from before this read
    case (word_index(addr))
      0: exp_rdata = m_control;
      1: exp_rdata = {m_rd_count, m_wr_count};
      2: exp_rdata = VERSION_WORD;
      3: exp_rdata = m_scratch;
      default: begin
        exp_rresp = RESP_SLVERR;
        exp_rdata = '0;
      end
    endcase
    m_rd_count = m_rd_count + 16'd1;
    txn_count++;
  endtask

  // Random stall of 0 to 3 cycles before taking the response
  task automatic take_b();
    int stall;
    while (!o_bvalid) begin
      @(negedge clk);
    end
    rng_state = xorshift32(rng_state);
    stall     = int'(rng_state[1:0]);
    repeat (stall) @(negedge clk);
    i_bready = 1'b1;
    @(negedge clk);
    i_bready = 1'b0;
  endtask

  task automatic take_r();
    int stall;
    while (!o_rvalid) begin
      @(negedge clk);
    end
    rng_state = xorshift32(rng_state);
    stall     = int'(rng_state[1:0]);
    repeat (stall) @(negedge clk);
    i_rready = 1'b1;
    @(negedge clk);
    i_rready = 1'b0;
  endtask

  task automatic write_txn(input logic [`AXI_ADDR_WIDTH-1:0] addr,
                           input logic [`AXI_DATA_WIDTH-1:0] data,
                           input int order);
    send_write_halves(addr, data, order);
    take_b();
  endtask

  task automatic read_txn(input logic [`AXI_ADDR_WIDTH-1:0] addr);
    send_read_addr(addr);
    take_r();
  endtask

  // Later AW/W handshake and AR handshake start the latency counters
  always @(posedge clk) begin
    if (w_axi_rst) begin
      aw_seen        <= 1'b0;
      w_seen         <= 1'b0;
      wr_lat         <= 0;
      rd_lat         <= 0;
      reads_accepted <= 0;
    end else begin
      if ((aw_seen || (i_awvalid && o_awready)) && (w_seen || (i_wvalid && o_wready))) begin
        aw_seen <= 1'b0;
        w_seen  <= 1'b0;
        wr_lat  <= 1;
      end else begin
        if (i_awvalid && o_awready) begin
          aw_seen <= 1'b1;
        end
        if (i_wvalid && o_wready) begin
          w_seen <= 1'b1;
        end
        if (wr_lat != 0 && wr_lat < 15) begin
          wr_lat <= wr_lat + 1;
        end
      end
      if (i_arvalid && o_arready) begin
        rd_lat         <= 1;
        reads_accepted <= reads_accepted + 1;
      end else if (rd_lat != 0 && rd_lat < 15) begin
        rd_lat <= rd_lat + 1;
      end
    end
  end

  bresp_matches: assert property (@(posedge clk) disable iff (w_axi_rst)
    o_bvalid |-> o_bresp == exp_bresp)
    else begin
      error_count++;
      $display("[FAIL] %0t o_bresp expected %0h actual %0h", $time, exp_bresp, $sampled(o_bresp));
    end

  // CONTROL output already updated by the time B is offered
  control_matches: assert property (@(posedge clk) disable iff (w_axi_rst)
    o_bvalid |-> o_control == m_control)
    else begin
      error_count++;
      $display("[FAIL] %0t o_control expected %0h actual %0h",
               $time, m_control, $sampled(o_control));
    end

  rdata_matches: assert property (@(posedge clk) disable iff (w_axi_rst)
    o_rvalid |-> o_rdata == exp_rdata)
    else begin
      error_count++;
      $display("[FAIL] %0t o_rdata expected %0h actual %0h", $time, exp_rdata, $sampled(o_rdata));
    end

  rresp_matches: assert property (@(posedge clk) disable iff (w_axi_rst)
    o_rvalid |-> o_rresp == exp_rresp)
    else begin
      error_count++;
      $display("[FAIL] %0t o_rresp expected %0h actual %0h", $time, exp_rresp, $sampled(o_rresp));
    end

  write_latency: assert property (@(posedge clk) disable iff (w_axi_rst)
    $rose(o_bvalid) |-> wr_lat == 3)
    else begin
      error_count++;
      $display("[FAIL] %0t BVALID latency expected 3 actual %0d", $time, $sampled(wr_lat));
    end

  read_latency: assert property (@(posedge clk) disable iff (w_axi_rst)
    $rose(o_rvalid) |-> rd_lat == 3)
    else begin
      error_count++;
      $display("[FAIL] %0t RVALID latency expected 3 actual %0d", $time, $sampled(rd_lat));
    end

  b_held: assert property (@(posedge clk) disable iff (w_axi_rst)
    o_bvalid && !i_bready |=> o_bvalid && $stable(o_bresp))
    else begin
      error_count++;
      $display("%0t B channel dropped or changed while BREADY was low", $time);
    end

  r_held: assert property (@(posedge clk) disable iff (w_axi_rst)
    o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata) && $stable(o_rresp))
    else begin
      error_count++;
      $display("%0t R channel dropped or changed while RREADY was low", $time);
    end

  readies_parked: assert property (@(posedge clk) disable iff (w_axi_rst)
    (o_bvalid || o_rvalid) |-> !(o_awready || o_wready || o_arready))
    else begin
      error_count++;
      $display("%0t a READY was high while a response was pending", $time);
    end

  write_priority: assert property (@(posedge clk) disable iff (w_axi_rst)
    o_arready |-> !(i_awvalid || i_wvalid))
    else begin
      error_count++;
      $display("%0t ARREADY was high while a write was offered", $time);
    end

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Summary: %0d transactions, %0d errors", txn_count, error_count);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    w_axi_rst   = 1'b1;
    i_awvalid   = 1'b0;
    i_awaddr    = '0;
    i_wvalid    = 1'b0;
    i_wdata     = '0;
    i_bready    = 1'b0;
    i_arvalid   = 1'b0;
    i_araddr    = '0;
    i_rready    = 1'b0;
    m_control   = '0;
    m_scratch   = '0;
    m_wr_count  = '0;
    m_rd_count  = '0;
    exp_bresp   = RESP_OKAY;
    exp_rresp   = RESP_OKAY;
    exp_rdata   = '0;
    error_count = 0;
    txn_count   = 0;
    rng_state   = 32'd60212;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    w_axi_rst = 1'b0;
    reset_state: assert (!o_bvalid && !o_rvalid && o_control == '0)
      else begin
        error_count++;
        $display("%0t outputs were not cleared by reset", $time);
      end

    // CONTROL and SCRATCH round trips, all three AW/W orders
    for (int i = 0; i < 10; i++) begin
      rng_state = xorshift32(rng_state);
      write_txn(8'h00, rng_state, i % 3);
      rng_state = xorshift32(rng_state);
      write_txn(8'h0C, rng_state, (i + 1) % 3);
      read_txn(8'h00);
      read_txn(8'h0C);
    end

    // Read-only words ignore writes
    read_txn(8'h08);
    write_txn(8'h04, 32'hFFFF_FFFF, 0);
    write_txn(8'h08, 32'hDEAD_BEEF, 1);
    read_txn(8'h08);
    read_txn(8'h04);

    // Out-of-range words, then byte offset on SCRATCH
    write_txn(8'h10, 32'h1234_5678, 2);
    write_txn(8'hFF, 32'h8765_4321, 0);
    read_txn(8'h10);
    read_txn(8'hFC);
    read_txn(8'h00);
    read_txn(8'h0E);

    // AW, W and AR offered in one cycle, write must finish first
    for (int i = 0; i < 2; i++) begin
      ar_before = reads_accepted;
      i_arvalid = 1'b1;
      i_araddr  = 8'h04;
      rng_state = xorshift32(rng_state);
      write_txn(8'h00, rng_state, 0);
      write_first: assert (reads_accepted == ar_before)
        else begin
          error_count++;
          $display("%0t read was accepted before the competing write finished", $time);
        end
      read_txn(8'h04);
    end

    // Random mix over valid and invalid words
    for (int i = 0; i < 8; i++) begin
      rng_state = xorshift32(rng_state);
      rand_addr = `AXI_ADDR_WIDTH'(rng_state[4:0]);
      if (rng_state[8]) begin
        write_txn(rand_addr, xorshift32(rng_state), int'(rng_state[10:9]) % 3);
      end else begin
        read_txn(rand_addr);
      end
    end

    read_txn(8'h04);
    repeat (4) @(negedge clk);
    $display("Summary: %0d transactions, %0d writes, %0d reads, %0d errors",
             txn_count, m_wr_count, m_rd_count, error_count);
    if (error_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
